//--- flist.f
hdl/sensor_pkg.sv
hdl/wb_addr_decode.sv
hdl/sensor_regs.sv
hdl/sample_fifo.sv
hdl/spi_sample_rx.sv
hdl/acq_sequencer.sv
hdl/dma_req_ctrl.sv
hdl/sensor_fpga_top.sv
verif/sensor_spi_model.sv
verif/tb_sensor_top.sv

//--- Makefile
TOP := tb_sensor_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -qx "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_sensor_top.sv
module tb_sensor_top;
    import sensor_pkg::*;

    localparam int FIFO_DEPTH   = 16;
    localparam int SPI_CLK_DIV  = 2;
    localparam int SAMPLE_GAP   = 8;
    localparam int DMA_BURST    = 4;
    localparam int RESET_CYC    = 16;
    localparam int ACK_LIMIT    = 20;
    localparam int N_SEQ        = 6;
    // One frame plus the gap, rounded up
    localparam int FRAME_CYC    = 32 * 2 * SPI_CLK_DIV + SAMPLE_GAP + 6;
    localparam int TEST_BUDGET  = 1000 + (2 * N_SEQ + 4) * FRAME_CYC
                                + (FIFO_DEPTH + 6) * FRAME_CYC + (DMA_BURST + 4) * FRAME_CYC;
    localparam int WATCHDOG_CYC = RESET_CYC + TEST_BUDGET + 2000;
    localparam wb_data_t SEQ_BASE = 32'hA5A5_0000;

    logic        wb_clk = 1'b0;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        csn;
    logic        sclk;
    logic        sdata;
    logic        dma_active;
    logic        dma_done;
    logic        dma_req;
    logic        intr;
    wb_data_t    device_id;
    int          cycle_cnt = 0;
    int          value_err = 0;
    int          proto_err = 0;
    int unsigned next_idx  = 0;       // Model frame expected next
    logic [15:0] lfsr_state = 16'd42910;

    always #10 wb_clk = ~wb_clk;

    always @(posedge wb_clk)
        cycle_cnt <= cycle_cnt + 1;

    sensor_fpga_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SPI_CLK_DIV (SPI_CLK_DIV),
        .SAMPLE_GAP  (SAMPLE_GAP),
        .DMA_BURST   (DMA_BURST)
    ) u_sensor_fpga_top (
        .wb_clk_i     (wb_clk),
        .rst_i        (rst),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .csn_o        (csn),
        .sclk_o       (sclk),
        .sdata_i      (sdata),
        .dma_active_i (dma_active),
        .dma_done_i   (dma_done),
        .dma_req_o    (dma_req),
        .intr_o       (intr),
        .device_id_o  (device_id)
    );

    sensor_spi_model #(
        .SEQ_BASE (SEQ_BASE)
    ) u_sensor_spi_model (
        .rst_i   (rst),
        .csn_i   (csn),
        .sclk_i  (sclk),
        .sdata_o (sdata)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11
    endfunction

    task automatic random_word(output wb_data_t w);
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic wb_addr_t reg_adr(input reg_ofs_t ofs);
        return REG_WIN_BASE + wb_addr_t'(ofs);
    endfunction

    function automatic wb_addr_t dma_adr(input reg_ofs_t ofs);
        return DMA_WIN_BASE + wb_addr_t'(ofs);
    endfunction

    task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
        if (exp !== act)
        begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            value_err++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            value_err++;
        end
    endtask

    // One bus transfer, request held until ack or the limit
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int   cnt;
        logic got;
        @(negedge wb_clk);
        wb_req.cyc  = 1'b1;
        wb_req.stb  = 1'b1;
        wb_req.we   = we;
        wb_req.adr  = adr;
        wb_req.wdat = wdat;
        cnt  = 0;
        got  = 1'b0;
        rdat = '0;
        while (!got && cnt < ACK_LIMIT)
        begin
            @(negedge wb_clk);
            cnt++;
            if (wb_rsp.ack)
            begin
                got  = 1'b1;
                rdat = wb_rsp.rdat;
            end
        end
        wb_req = '0;
        if (!got)
        begin
            $display("bus access to address %h got no ack within %0d cycles", adr, ACK_LIMIT);
            proto_err++;
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
        wb_data_t unused_rdat;
        wb_access(1'b1, adr, wdat, unused_rdat);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    // Poll LEVEL until it holds at least min_lvl samples
    task automatic wait_level(input int min_lvl, output wb_data_t lvl);
        int start;
        start = cycle_cnt;
        wb_read(reg_adr(LEVEL_ADR), lvl);
        while (lvl < wb_data_t'(min_lvl) && cycle_cnt - start < 2 * FRAME_CYC)
            wb_read(reg_adr(LEVEL_ADR), lvl);
        if (lvl < wb_data_t'(min_lvl))
        begin
            $display("FIFO level stayed below %0d for %0d cycles", min_lvl, 2 * FRAME_CYC);
            proto_err++;
        end
    endtask

    task automatic wait_frame_end;
        int start;
        repeat (2) @(negedge wb_clk); // A frame start may still be in flight
        start = cycle_cnt;
        while (!csn && cycle_cnt - start < FRAME_CYC)
            @(negedge wb_clk);
        if (!csn)
        begin
            $display("csn stayed low for %0d cycles after sensor enable cleared", FRAME_CYC);
            proto_err++;
        end
        repeat (4) @(negedge wb_clk);
    endtask

    task automatic probe_reg_map;
        wb_data_t d;
        wb_data_t w;
        check_bit("reset_csn", 1'b1, csn);
        check_bit("reset_sclk", 1'b0, sclk);
        check_bit("reset_dma_req", 1'b0, dma_req);
        check_bit("reset_intr", 1'b0, intr);
        check_data("device_id_pin", DEVICE_ID, device_id);
        wb_read(reg_adr(ID_ADR), d);
        check_data("id", DEVICE_ID, d);
        wb_read(reg_adr(REV_ADR), d);
        check_data("rev", REV_LEVEL, d);
        wb_read(reg_adr(SCRATCH_ADR), d);
        check_data("scratch_reset", SCRATCH_RESET, d);
        for (int i = 0; i < 3; i++)
        begin
            random_word(w);
            wb_write(reg_adr(SCRATCH_ADR), w);
            wb_read(reg_adr(SCRATCH_ADR), d);
            check_data($sformatf("scratch_rw_%0d", i), w, d);
        end
        wb_read(reg_adr(SENSOR_EN_ADR), d);
        check_data("sensor_en_reset", 32'd0, d);
        wb_read(reg_adr(OVERRUN_ADR), d);
        check_data("overrun_reset", 32'd0, d);
        wb_read(reg_adr(LEVEL_ADR), d);
        check_data("level_reset", 32'd0, d);
        wb_read(dma_adr(DMA_EN_ADR), d);
        check_data("dma_en_reset", 32'd0, d);
        wb_read(reg_adr(10'h01C), d);
        check_data("reg_undefined", REG_DEF_VALUE, d);
        wb_read(dma_adr(10'h00C), d);
        check_data("dma_undefined", REG_DEF_VALUE, d);
        wb_read(17'h08000, d);   // No window here
        check_data("unmapped", BAD_ACCESS_VALUE, d);
    endtask

    task automatic stream_samples;
        wb_data_t lvl;
        wb_data_t d;
        logic     csn_fell;
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd1);
        for (int i = 0; i < N_SEQ; i++)
        begin
            wait_level(1, lvl);
            check_bit($sformatf("stream_level_%0d", i), 1'b1, lvl < wb_data_t'(FIFO_DEPTH));
            wb_read(DATA_WIN_BASE, d);
            check_data($sformatf("stream_sample_%0d", i), SEQ_BASE + next_idx, d);
            next_idx++;
        end
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd0);
        wait_frame_end();
        csn_fell = 1'b0;
        repeat (2 * FRAME_CYC)
        begin
            @(negedge wb_clk);
            if (!csn)
                csn_fell = 1'b1;
        end
        check_bit("csn_idle_after_disable", 1'b0, csn_fell);
        // Samples that landed before the stop still follow the sequence
        wb_read(reg_adr(LEVEL_ADR), lvl);
        for (int i = 0; i < int'(lvl); i++)
        begin
            wb_read(DATA_WIN_BASE, d);
            check_data($sformatf("drain_sample_%0d", i), SEQ_BASE + next_idx, d);
            next_idx++;
        end
        wb_read(reg_adr(LEVEL_ADR), lvl);
        check_data("level_after_drain", 32'd0, lvl);
    endtask

    task automatic force_overrun;
        wb_data_t d;
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd1);
        repeat ((FIFO_DEPTH + 3) * FRAME_CYC) @(negedge wb_clk);
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd0);
        wait_frame_end();
        wb_read(reg_adr(OVERRUN_ADR), d);
        check_data("overrun_set", 32'd1, d);
        wb_read(reg_adr(LEVEL_ADR), d);
        check_data("level_full", wb_data_t'(FIFO_DEPTH), d);
        wb_write(reg_adr(FIFO_RST_ADR), 32'd1);
        wb_read(reg_adr(OVERRUN_ADR), d);
        check_data("overrun_cleared", 32'd0, d);
        wb_read(reg_adr(LEVEL_ADR), d);
        check_data("level_cleared", 32'd0, d);
    endtask

    task automatic read_empty_port;
        wb_data_t d;
        wb_read(DATA_WIN_BASE, d);
        check_data("empty_port_read", 32'd0, d);
        wb_read(reg_adr(LEVEL_ADR), d);
        check_data("empty_port_level", 32'd0, d);
    endtask

    task automatic exercise_dma;
        wb_data_t d;
        int       start;
        check_bit("dma_req_idle", 1'b0, dma_req);
        wb_write(dma_adr(DMA_EN_ADR), 32'd1);
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd1);
        start = cycle_cnt;
        while (!dma_req && cycle_cnt - start < (DMA_BURST + 2) * FRAME_CYC)
            @(negedge wb_clk);
        if (!dma_req)
        begin
            $display("DMA request never rose within %0d cycles", (DMA_BURST + 2) * FRAME_CYC);
            proto_err++;
        end
        wb_read(reg_adr(LEVEL_ADR), d);
        check_bit("dma_level_reached", 1'b1, d >= wb_data_t'(DMA_BURST));
        check_bit("intr_before_done", 1'b0, intr);
        dma_active = 1'b1;    // Transfer in progress
        dma_done   = 1'b1;
        @(negedge wb_clk);
        dma_done   = 1'b0;
        check_bit("dma_req_after_done", 1'b0, dma_req);
        wb_read(dma_adr(DMA_STS_ADR), d);
        check_data("dma_sts_set", 32'd1, d);
        check_bit("intr_masked", 1'b0, intr);
        wb_write(dma_adr(DMA_INTR_EN_ADR), 32'd1);
        check_bit("intr_enabled", 1'b1, intr);
        wb_write(dma_adr(DMA_INTR_EN_ADR), 32'd0);
        check_bit("intr_disabled", 1'b0, intr);
        wb_write(dma_adr(DMA_INTR_EN_ADR), 32'd1);
        check_bit("intr_reenabled", 1'b1, intr);
        wb_write(dma_adr(DMA_STS_ADR), 32'd1);
        wb_read(dma_adr(DMA_STS_ADR), d);
        check_data("dma_sts_cleared", 32'd0, d);
        check_bit("intr_cleared", 1'b0, intr);
        check_bit("dma_req_held_low", 1'b0, dma_req);
        wb_write(reg_adr(SENSOR_EN_ADR), 32'd0);
        wb_write(dma_adr(DMA_EN_ADR), 32'd0);
        dma_active = 1'b0;
    endtask

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge wb_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        rst        = 1'b1;
        wb_req     = '0;
        dma_active = 1'b0;
        dma_done   = 1'b0;
        repeat (RESET_CYC) @(negedge wb_clk);
        rst = 1'b0;
        probe_reg_map();
        stream_samples();
        force_overrun();
        read_empty_port();
        exercise_dma();
        $display("errors: %0d value, %0d protocol", value_err, proto_err);
        if (value_err == 0 && proto_err == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verif/sensor_spi_model.sv
module sensor_spi_model #(
    parameter logic [31:0] SEQ_BASE = 32'hA5A5_0000
) (
    input  logic rst_i,
    input  logic csn_i,
    input  logic sclk_i,
    output logic sdata_o
);

    logic [31:0] shreg;
    logic [31:0] frame_cnt;
    logic        in_frame;

    // Frame k carries SEQ_BASE + k, MSB first, new bit after each falling sclk
    initial
    begin
        sdata_o   = 1'b0;
        shreg     = '0;
        frame_cnt = '0;
        in_frame  = 1'b0;
        forever
        begin
            @(csn_i or negedge sclk_i or posedge rst_i);
            if (rst_i)
            begin
                frame_cnt = '0;
                in_frame  = 1'b0;
                sdata_o   = 1'b0;
            end
            else if (csn_i)
                in_frame = 1'b0; // Frame over
            else if (!in_frame)
            begin
                // Chip select just fell, present the MSB
                shreg     = SEQ_BASE + frame_cnt;
                frame_cnt = frame_cnt + 1;
                in_frame  = 1'b1;
                sdata_o   = shreg[31];
            end
            else
            begin
                shreg   = {shreg[30:0], 1'b0};
                sdata_o = shreg[31]; // Next bit before the rising edge
            end
        end
    end

endmodule

//--- hdl/sensor_fpga_top.sv
module sensor_fpga_top #(
    parameter int FIFO_DEPTH  = 16,
    parameter int SPI_CLK_DIV = 2,
    parameter int SAMPLE_GAP  = 8,
    parameter int DMA_BURST   = 4
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    input  sensor_pkg::wb_req_t  wb_req_i,
    output sensor_pkg::wb_rsp_t  wb_rsp_o,
    output logic                 csn_o,
    output logic                 sclk_o,
    input  logic                 sdata_i,
    input  logic                 dma_active_i,
    input  logic                 dma_done_i,
    output logic                 dma_req_o,
    output logic                 intr_o,
    output sensor_pkg::wb_data_t device_id_o
);
    import sensor_pkg::*;

    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    win_sel_t         win_sel;
    wb_rsp_t          regs_rsp;
    logic             sensor_en;
    logic             fifo_clr;
    logic             fifo_pop;
    sample_t          fifo_dout;
    logic [LVL_W-1:0] fifo_level;
    logic             fifo_empty;
    logic             overrun;
    logic             dma_en;
    logic             intr_en;
    logic             done_sts;
    logic             done_clr;
    logic             frame_start;
    logic             frame_done;
    logic             sample_valid;
    sample_t          sample;

    wb_addr_decode u_wb_addr_decode (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .wb_req_i   (wb_req_i),
        .win_sel_o  (win_sel),
        .regs_rsp_i (regs_rsp),
        .wb_rsp_o   (wb_rsp_o)
    );

    sensor_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sensor_regs (
        .wb_clk_i     (wb_clk_i),
        .rst_i        (rst_i),
        .wb_req_i     (wb_req_i),
        .win_sel_i    (win_sel),
        .rsp_o        (regs_rsp),
        .sensor_en_o  (sensor_en),
        .fifo_clr_o   (fifo_clr),
        .fifo_pop_o   (fifo_pop),
        .fifo_dout_i  (fifo_dout),
        .fifo_level_i (fifo_level),
        .fifo_empty_i (fifo_empty),
        .overrun_i    (overrun),
        .dma_en_o     (dma_en),
        .intr_en_o    (intr_en),
        .done_sts_i   (done_sts),
        .done_clr_o   (done_clr),
        .device_id_o  (device_id_o)
    );

    // Sample path
    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sample_fifo (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .clr_i       (fifo_clr),
        .push_i      (sample_valid),
        .push_data_i (sample),
        .pop_i       (fifo_pop),
        .dout_o      (fifo_dout),
        .level_o     (fifo_level),
        .empty_o     (fifo_empty),
        .overrun_o   (overrun)
    );

    spi_sample_rx #(
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) u_spi_sample_rx (
        .wb_clk_i       (wb_clk_i),
        .rst_i          (rst_i),
        .frame_start_i  (frame_start),
        .frame_done_o   (frame_done),
        .csn_o          (csn_o),
        .sclk_o         (sclk_o),
        .sdata_i        (sdata_i),
        .sample_valid_o (sample_valid),
        .sample_o       (sample)
    );

    acq_sequencer #(
        .SAMPLE_GAP (SAMPLE_GAP)
    ) u_acq_sequencer (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .sensor_en_i   (sensor_en),
        .frame_start_o (frame_start),
        .frame_done_i  (frame_done)
    );

    dma_req_ctrl #(
        .DMA_BURST  (DMA_BURST),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dma_req_ctrl (
        .wb_clk_i     (wb_clk_i),
        .rst_i        (rst_i),
        .dma_en_i     (dma_en),
        .intr_en_i    (intr_en),
        .fifo_level_i (fifo_level),
        .dma_active_i (dma_active_i),
        .dma_done_i   (dma_done_i),
        .dma_req_o    (dma_req_o),
        .done_sts_o   (done_sts),
        .done_clr_i   (done_clr),
        .intr_o       (intr_o)
    );

endmodule

//--- hdl/dma_req_ctrl.sv
module dma_req_ctrl #(
    parameter int DMA_BURST  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic                            dma_en_i,
    input  logic                            intr_en_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level_i,
    input  logic                            dma_active_i,
    input  logic                            dma_done_i,
    output logic                            dma_req_o,
    output logic                            done_sts_o,
    input  logic                            done_clr_i,
    output logic                            intr_o
);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    logic req_q;
    logic done_sts_q;
    logic burst_ready;

    assign burst_ready = (fifo_level_i >= LVL_W'(DMA_BURST));

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            req_q      <= 1'b0;
            done_sts_q <= 1'b0;
        end
        else
        begin
            if (dma_done_i)
                req_q <= 1'b0;
            else if (dma_en_i && !dma_active_i && burst_ready)
                req_q <= 1'b1; // Held until the transfer reports done

            if (dma_done_i)
                done_sts_q <= 1'b1;
            else if (done_clr_i)
                done_sts_q <= 1'b0;
        end
    end

    assign dma_req_o  = req_q;
    assign done_sts_o = done_sts_q;
    assign intr_o     = done_sts_q & intr_en_i;

endmodule

//--- hdl/acq_sequencer.sv
module acq_sequencer #(
    parameter int SAMPLE_GAP = 8
) (
    input  logic wb_clk_i,
    input  logic rst_i,
    input  logic sensor_en_i,
    output logic frame_start_o,
    input  logic frame_done_i
);
    import sensor_pkg::*;

    localparam int GAP_W = $clog2(SAMPLE_GAP + 1);

    acq_state_e       state_q;
    logic [GAP_W-1:0] gap_cnt_q;

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            state_q   <= ACQ_IDLE;
            gap_cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                ACQ_IDLE:
                    if (sensor_en_i)
                        state_q <= ACQ_START;
                ACQ_START:
                    state_q <= ACQ_WAIT_DONE;
                ACQ_WAIT_DONE:
                    if (frame_done_i)
                    begin
                        gap_cnt_q <= '0;
                        // Running frame always completes before idling
                        state_q   <= sensor_en_i ? ACQ_GAP : ACQ_IDLE;
                    end
                ACQ_GAP:
                    if (!sensor_en_i)
                        state_q <= ACQ_IDLE;
                    else if (gap_cnt_q == GAP_W'(SAMPLE_GAP - 1))
                        state_q <= ACQ_START;
                    else
                        gap_cnt_q <= gap_cnt_q + 1'b1;
                default:
                    state_q <= ACQ_IDLE;
            endcase
        end
    end

    assign frame_start_o = (state_q == ACQ_START);

endmodule

//--- hdl/spi_sample_rx.sv
module spi_sample_rx #(
    parameter int SPI_CLK_DIV = 2
) (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  logic                frame_start_i,
    output logic                frame_done_o,
    output logic                csn_o,
    output logic                sclk_o,
    input  logic                sdata_i,
    output logic                sample_valid_o,
    output sensor_pkg::sample_t sample_o
);
    import sensor_pkg::*;

    localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);

    spi_state_e       state_q;
    logic [DIV_W-1:0] div_cnt_q;
    logic [4:0]       bit_cnt_q;
    logic             sclk_q;
    logic             csn_q;
    logic             half_tick;
    sample_t          shreg_q;

    // End of one sclk half period
    assign half_tick = (div_cnt_q == DIV_W'(SPI_CLK_DIV - 1));

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            state_q   <= SPI_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            sclk_q    <= 1'b0;
            csn_q     <= 1'b1;
        end
        else
        begin
            case (state_q)
                SPI_IDLE:
                begin
                    div_cnt_q <= '0;
                    bit_cnt_q <= '0;
                    if (frame_start_i)
                    begin
                        state_q <= SPI_SHIFT;
                        csn_q   <= 1'b0;
                    end
                end
                SPI_SHIFT:
                begin
                    if (half_tick)
                    begin
                        div_cnt_q <= '0;
                        sclk_q    <= ~sclk_q;
                        if (sclk_q) // Falling edge closes a bit
                        begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == 5'd31)
                            begin
                                state_q <= SPI_FINISH;
                                csn_q   <= 1'b1;
                            end
                        end
                    end
                    else
                        div_cnt_q <= div_cnt_q + 1'b1;
                end
                SPI_FINISH:
                    state_q <= SPI_IDLE;
                default:
                    state_q <= SPI_IDLE;
            endcase
        end
    end

    // MSB first, taken as sclk rises
    always_ff @(posedge wb_clk_i)
    begin
        if (state_q == SPI_SHIFT && half_tick && !sclk_q)
            shreg_q <= {shreg_q[30:0], sdata_i};
    end

    assign csn_o          = csn_q;
    assign sclk_o         = sclk_q;
    assign sample_o       = shreg_q;
    assign sample_valid_o = (state_q == SPI_FINISH);
    assign frame_done_o   = (state_q == SPI_FINISH);

endmodule

//--- hdl/sample_fifo.sv
module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic                            clr_i,
    input  logic                            push_i,
    input  sensor_pkg::sample_t             push_data_i,
    input  logic                            pop_i,
    output sensor_pkg::sample_t             dout_o,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] level_o,
    output logic                            empty_o,
    output logic                            overrun_o
);
    import sensor_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    sample_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [LVL_W-1:0] level_q;
    logic             overrun_q;
    logic             full;
    logic             push_ok;
    logic             pop_ok;

    assign full    = (level_q == LVL_W'(FIFO_DEPTH));
    assign push_ok = push_i & ~full;
    assign pop_ok  = pop_i & (level_q != '0);

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i || clr_i)
        begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            level_q   <= '0;
            overrun_q <= 1'b0;
        end
        else
        begin
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two
            if (pop_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_ok && !pop_ok)
                level_q <= level_q + 1'b1;
            else if (pop_ok && !push_ok)
                level_q <= level_q - 1'b1;
            if (push_i && full)
                overrun_q <= 1'b1; // Sample lost, flag stays until clear
        end
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (push_ok)
            mem[wr_ptr_q] <= push_data_i;
    end

    assign dout_o    = mem[rd_ptr_q];
    assign level_o   = level_q;
    assign empty_o   = (level_q == '0);
    assign overrun_o = overrun_q;

endmodule

//--- hdl/sensor_regs.sv
module sensor_regs #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                               wb_clk_i,
    input  logic                               rst_i,
    input  sensor_pkg::wb_req_t                wb_req_i,
    input  sensor_pkg::win_sel_t               win_sel_i,
    output sensor_pkg::wb_rsp_t                rsp_o,
    output logic                               sensor_en_o,
    output logic                               fifo_clr_o,
    output logic                               fifo_pop_o,
    input  sensor_pkg::sample_t                fifo_dout_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_level_i,
    input  logic                               fifo_empty_i,
    input  logic                               overrun_i,
    output logic                               dma_en_o,
    output logic                               intr_en_o,
    input  logic                               done_sts_i,
    output logic                               done_clr_o,
    output sensor_pkg::wb_data_t               device_id_o
);
    import sensor_pkg::*;

    reg_ofs_t ofs;
    logic     acc;
    logic     wr;
    logic     rd;
    wb_data_t rd_mux;
    wb_data_t rdat_q;
    wb_data_t scratch_q;
    logic     ack_q;
    logic     sensor_en_q;
    logic     dma_en_q;
    logic     intr_en_q;
    logic     fifo_clr_q;
    logic     fifo_pop_q;
    logic     done_clr_q;

    assign ofs = wb_req_i.adr[9:0];
    assign acc = wb_req_i.cyc & wb_req_i.stb & ~ack_q &
                 (win_sel_i.reg_win | win_sel_i.dma_win | win_sel_i.data_win);
    assign wr  = acc & wb_req_i.we;
    assign rd  = acc & ~wb_req_i.we;

    always_comb
    begin
        rd_mux = REG_DEF_VALUE;
        if (win_sel_i.reg_win)
        begin
            case (ofs)
                ID_ADR:        rd_mux = DEVICE_ID;
                REV_ADR:       rd_mux = REV_LEVEL;
                FIFO_RST_ADR:  rd_mux = '0;          // Write-only strobe
                SENSOR_EN_ADR: rd_mux = wb_data_t'(sensor_en_q);
                OVERRUN_ADR:   rd_mux = wb_data_t'(overrun_i);
                LEVEL_ADR:     rd_mux = wb_data_t'(fifo_level_i);
                SCRATCH_ADR:   rd_mux = scratch_q;
                default:       rd_mux = REG_DEF_VALUE;
            endcase
        end
        else if (win_sel_i.dma_win)
        begin
            case (ofs)
                DMA_EN_ADR:      rd_mux = wb_data_t'(dma_en_q);
                DMA_STS_ADR:     rd_mux = wb_data_t'(done_sts_i);
                DMA_INTR_EN_ADR: rd_mux = wb_data_t'(intr_en_q);
                default:         rd_mux = REG_DEF_VALUE;
            endcase
        end
        else if (win_sel_i.data_win)
            rd_mux = fifo_empty_i ? '0 : fifo_dout_i; // Head of FIFO
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            ack_q       <= 1'b0;
            sensor_en_q <= 1'b0;
            dma_en_q    <= 1'b0;
            intr_en_q   <= 1'b0;
            scratch_q   <= SCRATCH_RESET;
            fifo_clr_q  <= 1'b0;
            fifo_pop_q  <= 1'b0;
            done_clr_q  <= 1'b0;
        end
        else
        begin
            ack_q      <= acc;
            fifo_clr_q <= wr & win_sel_i.reg_win & (ofs == FIFO_RST_ADR);
            done_clr_q <= wr & win_sel_i.dma_win & (ofs == DMA_STS_ADR) & wb_req_i.wdat[0];
            // Pop lines up with the ack of a data-port read
            fifo_pop_q <= rd & win_sel_i.data_win & ~fifo_empty_i;

            if (wr && win_sel_i.reg_win)
            begin
                if (ofs == SENSOR_EN_ADR)
                    sensor_en_q <= wb_req_i.wdat[0];
                if (ofs == SCRATCH_ADR)
                    scratch_q <= wb_req_i.wdat;
            end

            if (wr && win_sel_i.dma_win)
            begin
                if (ofs == DMA_EN_ADR)
                    dma_en_q <= wb_req_i.wdat[0];
                if (ofs == DMA_INTR_EN_ADR)
                    intr_en_q <= wb_req_i.wdat[0];
            end
        end
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (acc)
            rdat_q <= rd_mux;
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.rdat  = rdat_q;
    assign sensor_en_o = sensor_en_q;
    assign dma_en_o    = dma_en_q;
    assign intr_en_o   = intr_en_q;
    assign fifo_clr_o  = fifo_clr_q;
    assign fifo_pop_o  = fifo_pop_q;
    assign done_clr_o  = done_clr_q;
    assign device_id_o = DEVICE_ID;

endmodule

//--- hdl/wb_addr_decode.sv
module wb_addr_decode (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  sensor_pkg::wb_req_t  wb_req_i,
    output sensor_pkg::win_sel_t win_sel_o,
    input  sensor_pkg::wb_rsp_t  regs_rsp_i,
    output sensor_pkg::wb_rsp_t  wb_rsp_o
);
    import sensor_pkg::*;

    logic [4:0]                win_bits;
    win_sel_t                  win_sel;
    logic                      unmapped;
    logic [DEFAULT_CNTR_W-1:0] to_cnt_q;
    logic                      to_ack_q;

    assign win_bits = wb_req_i.adr[16:12];

    assign win_sel.reg_win  = wb_req_i.cyc & (win_bits == REG_WIN_BASE[16:12]);
    assign win_sel.dma_win  = wb_req_i.cyc & (win_bits == DMA_WIN_BASE[16:12]);
    assign win_sel.data_win = wb_req_i.cyc & (win_bits == DATA_WIN_BASE[16:12]);
    assign win_sel_o        = win_sel;

    // Nobody answers here, so the decoder does
    assign unmapped = wb_req_i.cyc & wb_req_i.stb &
                      ~(win_sel.reg_win | win_sel.dma_win | win_sel.data_win);

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            to_cnt_q <= '0;
            to_ack_q <= 1'b0;
        end
        else
        begin
            to_ack_q <= 1'b0;
            if (!unmapped || to_ack_q)
                to_cnt_q <= '0; // Restart once stb drops or after the ack
            else if (to_cnt_q == DEFAULT_CNTR_W'(DEFAULT_TIMEOUT - 1))
            begin
                to_ack_q <= 1'b1;
                to_cnt_q <= '0;
            end
            else
                to_cnt_q <= to_cnt_q + 1'b1;
        end
    end

    // Response merge
    always_comb
    begin
        wb_rsp_o.ack  = regs_rsp_i.ack | to_ack_q;
        wb_rsp_o.rdat = to_ack_q ? BAD_ACCESS_VALUE : regs_rsp_i.rdat;
    end

endmodule

//--- hdl/sensor_pkg.sv
package sensor_pkg;

    // Bus and sample widths
    typedef logic [16:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [9:0]  reg_ofs_t;
    typedef logic [31:0] sample_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t wdat;
    } wb_req_t;

    typedef struct packed {
        wb_data_t rdat;
        logic     ack;
    } wb_rsp_t;

    // All zero means an unmapped window
    typedef struct packed {
        logic reg_win;
        logic dma_win;
        logic data_win;
    } win_sel_t;

    typedef enum logic [1:0] {
        ACQ_IDLE,
        ACQ_START,
        ACQ_WAIT_DONE,
        ACQ_GAP
    } acq_state_e;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_FINISH
    } spi_state_e;

    // Window bases, decoded on adr[16:12]
    localparam wb_addr_t REG_WIN_BASE  = 17'h00000;
    localparam wb_addr_t DMA_WIN_BASE  = 17'h10000;
    localparam wb_addr_t DATA_WIN_BASE = 17'h11000;

    localparam reg_ofs_t ID_ADR        = 10'h000;
    localparam reg_ofs_t REV_ADR       = 10'h004;
    localparam reg_ofs_t FIFO_RST_ADR  = 10'h008;
    localparam reg_ofs_t SENSOR_EN_ADR = 10'h00C;
    localparam reg_ofs_t OVERRUN_ADR   = 10'h010;
    localparam reg_ofs_t LEVEL_ADR     = 10'h014;
    localparam reg_ofs_t SCRATCH_ADR   = 10'h018;

    localparam reg_ofs_t DMA_EN_ADR      = 10'h000;
    localparam reg_ofs_t DMA_STS_ADR     = 10'h004;
    localparam reg_ofs_t DMA_INTR_EN_ADR = 10'h008;

    localparam wb_data_t DEVICE_ID        = 32'h0000_5A17;
    localparam wb_data_t REV_LEVEL        = 32'h0001_0000;
    localparam wb_data_t SCRATCH_RESET    = 32'h1234_5678;
    localparam wb_data_t REG_DEF_VALUE    = 32'hFABD_EFAC; // Undefined offset in a window
    localparam wb_data_t BAD_ACCESS_VALUE = 32'hBADF_ABAC; // Unmapped window

    localparam int DEFAULT_TIMEOUT = 7;
    localparam int DEFAULT_CNTR_W  = 3;

endpackage
